// ==== design/bubble_loader_pkg.sv ====
package bubble_loader_pkg;

    // flash side
    typedef logic [11:0] page_t;
    typedef logic [2:0]  image_t;

    // {2'b00, image, page, 7'b0}, one 128 byte page per page number
    typedef logic [23:0] flash_addr_t;

    // output buffer and bad-loop table
    typedef logic [14:0] buf_addr_t;
    typedef logic [11:0] map_addr_t;

    localparam logic [7:0] FLASH_READ_OPCODE = 8'h03;    // single-bit read
    localparam int         CMD_BITS          = 32;       // opcode plus 24-bit address

    localparam page_t      BOOT_PAGE         = 12'h805;  // bootloader page of each image
    localparam int         BOOT_BITS         = 2656;

    // 1168 map bits, plus the 32 bits that follow them in flash
    localparam int         MAP_BITS          = 1200;

    localparam int         PAGE_HEAD_LOOPS   = 6;        // good loops written as 1
    localparam int         PAGE_DATA_BITS    = 1030;

    localparam buf_addr_t  BOOT_BUF_BASE     = 15'd0;
    localparam buf_addr_t  PAGE_BUF_BASE     = 15'd14336;

endpackage

// ==== design/flash_cmd_if.sv ====
`timescale 1ns/10ps

interface flash_cmd_if;
    import bubble_loader_pkg::*;

    logic        cmd_start;    // pulse, reader idle only
    flash_addr_t cmd_addr;
    logic        bit_req;      // pulse, one per data bit
    logic        cmd_end;      // pulse, raises chip select
    logic        cmd_ready;    // level, command bits are out
    logic        bit_valid;    // pulse, answers bit_req
    logic        bit_data;

    modport seq
    (
        output cmd_start, cmd_addr, bit_req, cmd_end,
        input  cmd_ready, bit_valid, bit_data
    );

    modport reader
    (
        input  cmd_start, cmd_addr, bit_req, cmd_end,
        output cmd_ready, bit_valid, bit_data
    );

endinterface

// ==== design/buf_wr_if.sv ====
`timescale 1ns/10ps

interface buf_wr_if;

    logic base_load;    // pulse, reload address counter
    logic base_page;    // 1 selects the page data base
    logic wr_strobe;    // pulse, one buffer bit
    logic wr_bit;

    modport seq
    (
        output base_load, base_page, wr_strobe, wr_bit
    );

    modport writer
    (
        input  base_load, base_page, wr_strobe, wr_bit
    );

endinterface

// ==== design/spi_flash_reader.sv ====
`timescale 1ns/10ps

module spi_flash_reader
(
    input  logic        MCLK,
    input  logic        reset,
    flash_cmd_if.reader cmd,
    output logic        flash_cs_n,
    output logic        flash_sclk,
    output logic        flash_mosi,
    input  logic        flash_miso
);
    import bubble_loader_pkg::*;

    typedef enum logic [2:0]
    {
        RD_IDLE,
        RD_CMD_LOW,
        RD_CMD_HIGH,
        RD_READY,
        RD_BIT_LOW
    } rd_state_t;

    rd_state_t           state;
    logic [CMD_BITS-1:0] shift_reg;
    logic [5:0]          bit_cnt;

    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            state         <= RD_IDLE;
            flash_cs_n    <= 1'b1;
            flash_sclk    <= 1'b1;
            flash_mosi    <= 1'b0;
            bit_cnt       <= '0;
            cmd.cmd_ready <= 1'b0;
            cmd.bit_valid <= 1'b0;
        end
        else
        begin
            cmd.bit_valid <= 1'b0;
            case (state)
                RD_IDLE:
                    if (cmd.cmd_start)
                    begin
                        flash_cs_n <= 1'b0;
                        bit_cnt    <= '0;
                        state      <= RD_CMD_LOW;
                    end
                RD_CMD_LOW:
                begin
                    flash_sclk <= 1'b0;
                    flash_mosi <= shift_reg[CMD_BITS-1];    // msb first
                    bit_cnt    <= bit_cnt + 1'b1;
                    state      <= RD_CMD_HIGH;
                end
                RD_CMD_HIGH:
                begin
                    flash_sclk <= 1'b1;    // flash latches mosi here
                    if (bit_cnt == CMD_BITS)
                    begin
                        cmd.cmd_ready <= 1'b1;
                        state         <= RD_READY;
                    end
                    else
                        state <= RD_CMD_LOW;
                end
                RD_READY:
                    if (cmd.cmd_end)
                    begin
                        flash_cs_n    <= 1'b1;
                        cmd.cmd_ready <= 1'b0;
                        state         <= RD_IDLE;
                    end
                    else if (cmd.bit_req)
                    begin
                        flash_sclk <= 1'b0;    // flash drives next bit
                        state      <= RD_BIT_LOW;
                    end
                RD_BIT_LOW:
                begin
                    flash_sclk    <= 1'b1;
                    cmd.bit_valid <= 1'b1;
                    state         <= RD_READY;
                end
                default:
                    state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (state == RD_IDLE && cmd.cmd_start)
            shift_reg <= {FLASH_READ_OPCODE, cmd.cmd_addr};
        else if (state == RD_CMD_LOW)
            shift_reg <= {shift_reg[CMD_BITS-2:0], 1'b0};
        if (state == RD_BIT_LOW)
            cmd.bit_data <= flash_miso;    // sampled with the rising sclk
    end

endmodule

// ==== design/bad_loop_map.sv ====
`timescale 1ns/10ps

module bad_loop_map
(
    input  logic                         MCLK,
    input  logic                         wr_en,
    input  logic                         rd_en,
    input  bubble_loader_pkg::map_addr_t addr,
    input  logic                         wr_bit,
    output logic                         rd_bit
);

    logic table_mem [0:4095];    // 1 = good loop

    // the map is stored in flash with each 16-loop group reversed
    always_ff @(posedge MCLK)
    begin
        if (wr_en)
            table_mem[{addr[11:4], ~addr[3:0]}] <= wr_bit;
    end

    always_ff @(posedge MCLK)
    begin
        if (rd_en)
            rd_bit <= table_mem[addr];
    end

endmodule

// ==== design/load_sequencer.sv ====
`timescale 1ns/10ps

module load_sequencer
(
    input  logic                          MCLK,
    input  logic                          reset,
    input  logic                          start,
    input  logic                          boot_sel,
    input  bubble_loader_pkg::image_t     image,
    input  bubble_loader_pkg::page_t      page,
    output logic                          done,
    flash_cmd_if.seq                      cmd,
    buf_wr_if.seq                         wbuf,
    output logic                          map_wr_en,
    output logic                          map_rd_en,
    output bubble_loader_pkg::map_addr_t  map_addr,
    output logic                          map_wr_bit,
    input  logic                          map_rd_bit
);
    import bubble_loader_pkg::*;

    typedef enum logic [3:0]
    {
        SQ_IDLE,
        SQ_WAIT_READY,
        SQ_BOOT_REQ,
        SQ_BOOT_WAIT,
        SQ_PAGE_RD,
        SQ_PAGE_CHK,
        SQ_PAGE_WAIT,
        SQ_FINISH,
        SQ_DONE
    } sq_state_t;

    sq_state_t   state;
    logic        is_boot;
    logic [11:0] cnt;    // boot bits, or good loops in a page

    assign map_rd_en = (state == SQ_PAGE_RD);

    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            state          <= SQ_IDLE;
            is_boot        <= 1'b0;
            cnt            <= '0;
            map_addr       <= '0;
            map_wr_en      <= 1'b0;
            done           <= 1'b0;
            cmd.cmd_start  <= 1'b0;
            cmd.bit_req    <= 1'b0;
            cmd.cmd_end    <= 1'b0;
            wbuf.base_load <= 1'b0;
            wbuf.wr_strobe <= 1'b0;
        end
        else
        begin
            map_wr_en      <= 1'b0;
            done           <= 1'b0;
            cmd.cmd_start  <= 1'b0;
            cmd.bit_req    <= 1'b0;
            cmd.cmd_end    <= 1'b0;
            wbuf.base_load <= 1'b0;
            wbuf.wr_strobe <= 1'b0;
            case (state)
                SQ_IDLE:
                    if (start)    // ignored anywhere else
                    begin
                        is_boot        <= boot_sel;
                        cnt            <= '0;
                        map_addr       <= '0;
                        cmd.cmd_start  <= 1'b1;
                        wbuf.base_load <= 1'b1;
                        state          <= SQ_WAIT_READY;
                    end
                SQ_WAIT_READY:
                    if (cmd.cmd_ready)
                        state <= is_boot ? SQ_BOOT_REQ : SQ_PAGE_RD;
                SQ_BOOT_REQ:
                    if (cnt == BOOT_BITS + MAP_BITS)
                        state <= SQ_FINISH;
                    else
                    begin
                        cmd.bit_req <= 1'b1;
                        state       <= SQ_BOOT_WAIT;
                    end
                SQ_BOOT_WAIT:
                    if (cmd.bit_valid)
                    begin
                        wbuf.wr_strobe <= 1'b1;
                        if (cnt >= BOOT_BITS)    // map bits also go to the table
                        begin
                            map_wr_en <= 1'b1;
                            map_addr  <= map_addr_t'(cnt - BOOT_BITS);
                        end
                        cnt   <= cnt + 1'b1;
                        state <= SQ_BOOT_REQ;
                    end
                SQ_PAGE_RD:
                begin
                    map_addr <= map_addr + 1'b1;
                    state    <= SQ_PAGE_CHK;
                end
                SQ_PAGE_CHK:
                    if (!map_rd_bit)
                    begin
                        wbuf.wr_strobe <= 1'b1;    // bad loop, no flash bit used
                        state          <= SQ_PAGE_RD;
                    end
                    else if (cnt < PAGE_HEAD_LOOPS)
                    begin
                        wbuf.wr_strobe <= 1'b1;
                        cnt            <= cnt + 1'b1;
                        state          <= SQ_PAGE_RD;
                    end
                    else
                    begin
                        cmd.bit_req <= 1'b1;
                        state       <= SQ_PAGE_WAIT;
                    end
                SQ_PAGE_WAIT:
                    if (cmd.bit_valid)
                    begin
                        wbuf.wr_strobe <= 1'b1;
                        cnt            <= cnt + 1'b1;
                        if (cnt == PAGE_HEAD_LOOPS + PAGE_DATA_BITS - 1)
                            state <= SQ_FINISH;
                        else
                            state <= SQ_PAGE_RD;
                    end
                SQ_FINISH:
                begin
                    cmd.cmd_end <= 1'b1;
                    state       <= SQ_DONE;
                end
                SQ_DONE:
                begin
                    done  <= 1'b1;    // last buffer write is already out
                    state <= SQ_IDLE;
                end
                default:
                    state <= SQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (state == SQ_IDLE && start)
        begin
            cmd.cmd_addr   <= {2'b00, image, (boot_sel ? BOOT_PAGE : page), 7'b000_0000};
            wbuf.base_page <= !boot_sel;
        end
        if (cmd.bit_valid)
        begin
            wbuf.wr_bit <= cmd.bit_data;
            map_wr_bit  <= cmd.bit_data;
        end
        else if (state == SQ_PAGE_CHK)
            wbuf.wr_bit <= map_rd_bit;    // 0 for bad loop, 1 for head
    end

endmodule

// ==== design/out_buffer_writer.sv ====
`timescale 1ns/10ps

module out_buffer_writer
(
    input  logic                         MCLK,
    input  logic                         reset,
    buf_wr_if.writer                     wbuf,
    output logic                         buf_wr_en,
    output bubble_loader_pkg::buf_addr_t buf_wr_addr,
    output logic                         buf_wr_data
);
    import bubble_loader_pkg::*;

    buf_addr_t wr_ptr;

    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            wr_ptr    <= BOOT_BUF_BASE;
            buf_wr_en <= 1'b0;
        end
        else
        begin
            buf_wr_en <= wbuf.wr_strobe;
            if (wbuf.base_load)
                wr_ptr <= wbuf.base_page ? PAGE_BUF_BASE : BOOT_BUF_BASE;
            else if (wbuf.wr_strobe)
                wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (wbuf.wr_strobe)
        begin
            buf_wr_addr <= wr_ptr;    // address before the increment
            buf_wr_data <= wbuf.wr_bit;
        end
    end

endmodule

// ==== design/spi_loader.sv ====
`timescale 1ns/10ps

module spi_loader
(
    input  logic                         MCLK,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         boot_sel,      // 1 = bootloader access
    input  bubble_loader_pkg::image_t    image,
    input  bubble_loader_pkg::page_t     page,
    output logic                         done,
    output logic                         flash_cs_n,
    output logic                         flash_sclk,
    output logic                         flash_mosi,
    input  logic                         flash_miso,
    output logic                         buf_wr_en,
    output bubble_loader_pkg::buf_addr_t buf_wr_addr,
    output logic                         buf_wr_data
);

    flash_cmd_if cmd_bus ();
    buf_wr_if    buf_bus ();

    logic                         map_wr_en;
    logic                         map_rd_en;
    bubble_loader_pkg::map_addr_t map_addr;
    logic                         map_wr_bit;
    logic                         map_rd_bit;

    spi_flash_reader i_spi_flash_reader
    (
        .MCLK       (MCLK),
        .reset      (reset),
        .cmd        (cmd_bus.reader),
        .flash_cs_n (flash_cs_n),
        .flash_sclk (flash_sclk),
        .flash_mosi (flash_mosi),
        .flash_miso (flash_miso)
    );

    load_sequencer i_load_sequencer
    (
        .MCLK       (MCLK),
        .reset      (reset),
        .start      (start),
        .boot_sel   (boot_sel),
        .image      (image),
        .page       (page),
        .done       (done),
        .cmd        (cmd_bus.seq),
        .wbuf       (buf_bus.seq),
        .map_wr_en  (map_wr_en),
        .map_rd_en  (map_rd_en),
        .map_addr   (map_addr),
        .map_wr_bit (map_wr_bit),
        .map_rd_bit (map_rd_bit)
    );

    bad_loop_map i_bad_loop_map
    (
        .MCLK   (MCLK),
        .wr_en  (map_wr_en),
        .rd_en  (map_rd_en),
        .addr   (map_addr),
        .wr_bit (map_wr_bit),
        .rd_bit (map_rd_bit)
    );

    out_buffer_writer i_out_buffer_writer
    (
        .MCLK        (MCLK),
        .reset       (reset),
        .wbuf        (buf_bus.writer),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_data (buf_wr_data)
    );

endmodule

// ==== dv/flash_model.sv ====
`timescale 1ns/10ps

module flash_model
(
    input  logic        cs_n,
    input  logic        sclk,
    input  logic        mosi,
    output logic        miso,
    output logic [31:0] cmd_word,     // last command received
    output int          cmd_count
);
    import bubble_loader_pkg::*;

    logic        map_bits [0:MAP_BITS-1];
    logic [23:0] rd_addr;
    int          bit_idx;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic data_bit(input logic [23:0] addr, input int idx);
        logic [31:0] pos;
        if (addr[18:7] == BOOT_PAGE && idx >= BOOT_BITS && idx < BOOT_BITS + MAP_BITS)
            return map_bits[idx - BOOT_BITS];    // bad-loop map after the boot stream
        pos = {5'b0, addr, 3'b000} + idx;
        return (^pos) ^ addr[19];                 // addr[19] is the image lsb
    endfunction

    // a bad loop can only sit on every eighth map position,
    // so each page still finds enough good loops
    initial
    begin
        logic [31:0] lfsr;
        lfsr = 32'h45ba_88ff;
        for (int k = 0; k < MAP_BITS; k++)
        begin
            lfsr        = lfsr_next(lfsr);
            map_bits[k] = lfsr[0] | (k % 8 != 0);
        end
    end

    initial
    begin
        miso      = 1'b0;
        cmd_word  = '0;
        cmd_count = 0;
        forever
        begin
            @(negedge cs_n);
            for (int i = 0; i < CMD_BITS; i++)
            begin
                @(posedge sclk);
                cmd_word = {cmd_word[30:0], mosi};    // opcode, then address
            end
            cmd_count = cmd_count + 1;
            rd_addr   = cmd_word[23:0];
            bit_idx   = 0;
            while (cs_n == 1'b0)
            begin
                @(negedge sclk or posedge cs_n);
                if (cs_n == 1'b0)
                begin
                    miso    <= data_bit(rd_addr, bit_idx);
                    bit_idx = bit_idx + 1;
                end
            end
        end
    end

endmodule

// ==== dv/tb_spi_loader.sv ====
`timescale 1ns/10ps

module tb_spi_loader;
    import bubble_loader_pkg::*;

    localparam int TIMEOUT_CYCLES = 60000;
    localparam int NUM_ACCESSES   = 6;

    typedef struct packed
    {
        logic      boot_sel;
        image_t    image;
        page_t     page;
        logic      busy_start;    // second start while busy
        page_t     exp_page;      // page inside the flash command
        buf_addr_t exp_base;
    } access_t;

    // page access needs the table from an earlier boot access
    access_t accesses [0:NUM_ACCESSES-1] = '{
        '{1'b1, 3'd0, 12'h000, 1'b0, BOOT_PAGE, BOOT_BUF_BASE},
        '{1'b0, 3'd0, 12'h010, 1'b0, 12'h010,   PAGE_BUF_BASE},
        '{1'b0, 3'd0, 12'h7ff, 1'b1, 12'h7ff,   PAGE_BUF_BASE},
        '{1'b1, 3'd5, 12'h3c1, 1'b1, BOOT_PAGE, BOOT_BUF_BASE},
        '{1'b0, 3'd5, 12'h123, 1'b0, 12'h123,   PAGE_BUF_BASE},
        '{1'b0, 3'd5, 12'h010, 1'b0, 12'h010,   PAGE_BUF_BASE}
    };

    logic        MCLK;
    logic        reset;
    logic        start;
    logic        boot_sel;
    image_t      image;
    page_t       page;
    logic        done;
    logic        flash_cs_n;
    logic        flash_sclk;
    logic        flash_mosi;
    logic        flash_miso;
    logic        buf_wr_en;
    buf_addr_t   buf_wr_addr;
    logic        buf_wr_data;
    logic [31:0] cmd_word;
    int          cmd_count;
    logic        captured [int];    // buffer contents by address
    int          write_count = 0;
    int          done_count  = 0;
    logic        map_stream [0:MAP_BITS-1];

    spi_loader i_spi_loader
    (
        .MCLK        (MCLK),
        .reset       (reset),
        .start       (start),
        .boot_sel    (boot_sel),
        .image       (image),
        .page        (page),
        .done        (done),
        .flash_cs_n  (flash_cs_n),
        .flash_sclk  (flash_sclk),
        .flash_mosi  (flash_mosi),
        .flash_miso  (flash_miso),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_data (buf_wr_data)
    );

    flash_model i_flash_model
    (
        .cs_n      (flash_cs_n),
        .sclk      (flash_sclk),
        .mosi      (flash_mosi),
        .miso      (flash_miso),
        .cmd_word  (cmd_word),
        .cmd_count (cmd_count)
    );

    initial
    begin
        MCLK = 1'b0;
        forever
            #10 MCLK = ~MCLK;
    end

    always @(negedge MCLK)    // outputs settled mid cycle
    begin
        if (buf_wr_en === 1'b1)
        begin
            captured[int'(buf_wr_addr)] = buf_wr_data;
            write_count = write_count + 1;
        end
        if (done === 1'b1)
            done_count = done_count + 1;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic build_map_stream();
        logic [31:0] lfsr;
        lfsr = 32'h45ba_88ff;
        for (int k = 0; k < MAP_BITS; k++)
        begin
            lfsr          = lfsr_next(lfsr);
            map_stream[k] = lfsr[0] | (k % 8 != 0);    // bad only on every eighth bit
        end
    endtask

    function automatic logic expected_bit(input image_t img, input page_t pg, input int idx);
        logic [31:0] pos;
        if (pg == BOOT_PAGE && idx >= BOOT_BITS)
            return map_stream[idx - BOOT_BITS];
        pos = {7'b0, img, pg, 7'b0, 3'b000} + idx;    // byte address times 8 plus index
        return (^pos) ^ img[0];
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            abort_run($sformatf("error at %0t ns: %s is %0h, expected %0h",
                                $time, name, actual, expected));
    endtask

    task automatic check_slot(input int addr, input logic expected);
        if (!captured.exists(addr))
            abort_run($sformatf("no buffer write reached address %0d", addr));
        else
            check_value($sformatf("buffer[%0d]", addr), captured[addr], expected);
    endtask

    task automatic check_boot_image(input image_t img, input buf_addr_t base);
        for (int a = 0; a < BOOT_BITS + MAP_BITS; a++)
            check_slot(base + a, expected_bit(img, BOOT_PAGE, a));
        check_value("buf_wr_en pulses", write_count, BOOT_BITS + MAP_BITS);
    endtask

    task automatic check_page_image(input image_t img, input page_t pg, input buf_addr_t base);
        int   slot;
        int   good;
        logic exp;
        slot = 0;
        good = 0;
        while (good < PAGE_HEAD_LOOPS + PAGE_DATA_BITS)
        begin
            if (!map_stream[slot ^ 15])
                exp = 1'b0;    // bad loop
            else if (good < PAGE_HEAD_LOOPS)
            begin
                exp  = 1'b1;
                good = good + 1;
            end
            else
            begin
                exp  = expected_bit(img, pg, good - PAGE_HEAD_LOOPS);
                good = good + 1;
            end
            check_slot(base + slot, exp);
            slot = slot + 1;
        end
        check_value("buf_wr_en pulses", write_count, slot);
    endtask

    task automatic pulse_start(input logic boot, input image_t img, input page_t pg);
        @(posedge MCLK);
        #2;
        start    = 1'b1;
        boot_sel = boot;
        image    = img;
        page     = pg;
        @(posedge MCLK);
        #2;
        start = 1'b0;
    endtask

    task automatic wait_done(input int target);
        int cycles;
        cycles = 0;
        while (done_count < target && cycles < TIMEOUT_CYCLES)
        begin
            @(posedge MCLK);
            cycles = cycles + 1;
        end
        if (done_count < target)
            abort_run("timeout: the loader never signalled done");
    endtask

    initial
    begin
        reset    = 1'b1;
        start    = 1'b0;
        boot_sel = 1'b0;
        image    = '0;
        page     = '0;
        build_map_stream();
        repeat (3) @(posedge MCLK);
        #2;
        reset = 1'b0;
        repeat (8)
        begin
            @(negedge MCLK);
            check_value("flash_cs_n", flash_cs_n, 1);
            check_value("flash_sclk", flash_sclk, 1);
            check_value("buf_wr_en", buf_wr_en, 0);
            check_value("done", done, 0);
        end
        for (int i = 0; i < NUM_ACCESSES; i++)
        begin
            captured.delete();
            write_count = 0;
            pulse_start(accesses[i].boot_sel, accesses[i].image, accesses[i].page);
            if (accesses[i].busy_start)
            begin
                repeat (100) @(posedge MCLK);
                pulse_start(!accesses[i].boot_sel, ~accesses[i].image,
                            page_t'(accesses[i].page + 1));
            end
            wait_done(i + 1);
            repeat (10) @(negedge MCLK);
            check_value("done pulses", done_count, i + 1);
            check_value("flash_cs_n", flash_cs_n, 1);
            check_value("flash commands", cmd_count, i + 1);
            check_value("flash command", cmd_word, {FLASH_READ_OPCODE, 2'b00,
                        accesses[i].image, accesses[i].exp_page, 7'b000_0000});
            if (accesses[i].boot_sel)
                check_boot_image(accesses[i].image, accesses[i].exp_base);
            else
                check_page_image(accesses[i].image, accesses[i].page, accesses[i].exp_base);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== filelist.f ====
design/bubble_loader_pkg.sv
design/flash_cmd_if.sv
design/buf_wr_if.sv
design/spi_flash_reader.sv
design/bad_loop_map.sv
design/load_sequencer.sv
design/out_buffer_writer.sv
design/spi_loader.sv
dv/flash_model.sv
dv/tb_spi_loader.sv

// ==== Bender.yml ====
package:
  name: spi_loader

sources:
  - files:
      - design/bubble_loader_pkg.sv
      - design/flash_cmd_if.sv
      - design/buf_wr_if.sv
      - design/spi_flash_reader.sv
      - design/bad_loop_map.sv
      - design/load_sequencer.sv
      - design/out_buffer_writer.sv
      - design/spi_loader.sv
  - target: test
    files:
      - dv/flash_model.sv
      - dv/tb_spi_loader.sv
